// File: design/wisc_pkg.sv
/*
 * Shared widths, types and encodings for the reduced 16-bit pipelined core.
 * Every design file refers to these by scoped name.
 */
package wisc_pkg;

	localparam int WORD_W = 16;
	localparam int REG_IDX_W = 3;
	localparam int NUM_REGS = 1 << REG_IDX_W;

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [WORD_W-1:0] instr_t;
	typedef logic [REG_IDX_W-1:0] reg_idx_t;
	typedef logic [4:0] opcode_t;
	typedef logic [1:0] funct_t;
	typedef logic [2:0] alu_sel_t;

	// Instruction field positions
	localparam int OP_MSB = 15;
	localparam int OP_LSB = 11;
	localparam int RS_MSB = 10;
	localparam int RS_LSB = 8;
	localparam int RT_MSB = 7;
	localparam int RT_LSB = 5;
	localparam int RD_MSB = 4;
	localparam int RD_LSB = 2;
	localparam int IMM5_MSB = 4;
	localparam int IMM8_MSB = 7;
	localparam int FN_MSB = 1;

	localparam opcode_t OP_HALT = 5'b00000;
	localparam opcode_t OP_NOP  = 5'b00001;
	localparam opcode_t OP_ADDI = 5'b01000;
	localparam opcode_t OP_SUBI = 5'b01001;
	localparam opcode_t OP_BEQZ = 5'b01100;
	localparam opcode_t OP_BNEZ = 5'b01101;
	localparam opcode_t OP_ST   = 5'b10000;
	localparam opcode_t OP_LBI  = 5'b11000;
	localparam opcode_t OP_ALU  = 5'b11011;

	// Function field of the register operations
	localparam funct_t FN_ADD  = 2'b00;
	localparam funct_t FN_SUB  = 2'b01;
	localparam funct_t FN_XOR  = 2'b10;
	localparam funct_t FN_ANDN = 2'b11;

	localparam instr_t NOP_INSTR = {OP_NOP, 11'b0};

	// Result selectors used inside execute
	localparam alu_sel_t SEL_ADD  = 3'd0;
	localparam alu_sel_t SEL_SUBI = 3'd1;
	localparam alu_sel_t SEL_SUB  = 3'd2;
	localparam alu_sel_t SEL_XOR  = 3'd3;
	localparam alu_sel_t SEL_ANDN = 3'd4;
	localparam alu_sel_t SEL_IMM  = 3'd5;

endpackage

// File: design/id_ex_if.sv
/*
 * Decoded instruction passed from decode into execute.
 * Registered in decode and updated every cycle, with no handshake.
 */
interface id_ex_if;

	logic                valid;
	wisc_pkg::word_t     op_a;
	wisc_pkg::word_t     op_b;
	wisc_pkg::word_t     imm;
	wisc_pkg::alu_sel_t  alu_sel;
	logic                use_imm;
	logic                reg_write;
	wisc_pkg::reg_idx_t  dest;
	logic                store;
	logic                halt;

	modport src (output valid, op_a, op_b, imm, alu_sel, use_imm,
		reg_write, dest, store, halt);

	modport dst (input valid, op_a, op_b, imm, alu_sel, use_imm,
		reg_write, dest, store, halt);

endinterface

// File: design/fwd_if.sv
/*
 * Result taps fed back to decode and the register file.
 * Execute drives the ex and mem taps, writeback drives the wb tap.
 */
interface fwd_if;

	logic               ex_we;
	wisc_pkg::reg_idx_t ex_idx;
	wisc_pkg::word_t    ex_data;
	logic               mem_we;
	wisc_pkg::reg_idx_t mem_idx;
	wisc_pkg::word_t    mem_data;
	logic               wb_we;
	wisc_pkg::reg_idx_t wb_idx;
	wisc_pkg::word_t    wb_data;

	modport ex_src (output ex_we, ex_idx, ex_data, mem_we, mem_idx, mem_data);
	modport wb_src (input mem_we, mem_idx, mem_data, output wb_we, wb_idx, wb_data);
	modport consumer (input ex_we, ex_idx, ex_data, mem_we, mem_idx, mem_data,
		wb_we, wb_idx, wb_data);

endinterface

// File: design/fetch_stage.sv
/*
 * Program counter and the fetch/decode register.
 * A redirect or a freeze puts a NOP into decode in place of the fetched word.
 */
module fetch_stage #(
	parameter wisc_pkg::word_t RESET_PC = '0
) (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               redirect,
	input  wisc_pkg::word_t    target,
	input  logic               freeze,
	input  wisc_pkg::instr_t   instr,
	output wisc_pkg::word_t    pc,
	output wisc_pkg::instr_t   fd_instr,
	output wisc_pkg::word_t    fd_pc2
);

	wisc_pkg::word_t pc_q;
	wisc_pkg::word_t pc2;

	assign pc = pc_q;
	assign pc2 = pc_q + wisc_pkg::word_t'(2);

	// Branch target wins over freeze
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			pc_q <= RESET_PC;
		else if (redirect)
			pc_q <= target;
		else if (!freeze)
			pc_q <= pc2;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			fd_instr <= wisc_pkg::NOP_INSTR;
		else
			fd_instr <= (redirect || freeze) ? wisc_pkg::NOP_INSTR : instr;
	end

	always_ff @(posedge clk) begin
		fd_pc2 <= pc2;
	end

endmodule

// File: design/reg_file.sv
/*
 * Eight general registers, written from the writeback tap.
 * A read of the register written in the same cycle sees the new value.
 */
module reg_file (
	input  logic                clk,
	input  logic                rst_n,
	input  wisc_pkg::reg_idx_t  rd_sel1,
	input  wisc_pkg::reg_idx_t  rd_sel2,
	output wisc_pkg::word_t     rd_data1,
	output wisc_pkg::word_t     rd_data2,
	fwd_if.consumer             fwd
);

	wisc_pkg::word_t regs [wisc_pkg::NUM_REGS];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			regs <= '{default: '0};
		else if (fwd.wb_we)
			regs[fwd.wb_idx] <= fwd.wb_data;
	end

	// Write-before-read bypass
	assign rd_data1 = (fwd.wb_we && fwd.wb_idx == rd_sel1) ? fwd.wb_data : regs[rd_sel1];
	assign rd_data2 = (fwd.wb_we && fwd.wb_idx == rd_sel2) ? fwd.wb_data : regs[rd_sel2];

endmodule

// File: design/decode_stage.sv
/*
 * Decode: control bits, operand forwarding, branch resolution and halt/error.
 * Loads the decode/execute register every cycle, NOPs once stopped.
 */
module decode_stage (
	input  logic               clk,
	input  logic               rst_n,
	input  wisc_pkg::instr_t   fd_instr,
	input  wisc_pkg::word_t    fd_pc2,
	fwd_if.consumer            fwd,
	id_ex_if.src               ex,
	output logic               redirect,
	output wisc_pkg::word_t    target,
	output logic               freeze,
	output logic               err
);

	wisc_pkg::opcode_t  opcode;
	wisc_pkg::funct_t   funct;
	wisc_pkg::reg_idx_t rs, rt, rd, dest;
	wisc_pkg::word_t    imm5_sx, imm8_sx, imm_val;
	wisc_pkg::word_t    rf_a, rf_b, val_a, val_b;
	wisc_pkg::alu_sel_t alu_sel;
	logic use_imm, reg_write, store, is_branch, is_halt, illegal;
	logic stop_q, err_q;

	// Youngest producer first
	function automatic wisc_pkg::word_t fwd_pick(input wisc_pkg::reg_idx_t idx,
		input wisc_pkg::word_t rf_val);
		if (fwd.ex_we && fwd.ex_idx == idx)
			return fwd.ex_data;
		if (fwd.mem_we && fwd.mem_idx == idx)
			return fwd.mem_data;
		if (fwd.wb_we && fwd.wb_idx == idx)
			return fwd.wb_data;
		return rf_val;
	endfunction

	assign opcode = fd_instr[wisc_pkg::OP_MSB:wisc_pkg::OP_LSB];
	assign funct = fd_instr[wisc_pkg::FN_MSB:0];
	assign rs = fd_instr[wisc_pkg::RS_MSB:wisc_pkg::RS_LSB];
	assign rt = fd_instr[wisc_pkg::RT_MSB:wisc_pkg::RT_LSB];
	assign rd = fd_instr[wisc_pkg::RD_MSB:wisc_pkg::RD_LSB];
	assign imm5_sx = {{(wisc_pkg::WORD_W-wisc_pkg::IMM5_MSB-1){fd_instr[wisc_pkg::IMM5_MSB]}},
		fd_instr[wisc_pkg::IMM5_MSB:0]};
	assign imm8_sx = {{(wisc_pkg::WORD_W-wisc_pkg::IMM8_MSB-1){fd_instr[wisc_pkg::IMM8_MSB]}},
		fd_instr[wisc_pkg::IMM8_MSB:0]};
	assign imm_val = (opcode == wisc_pkg::OP_LBI) ? imm8_sx : imm5_sx;

	reg_file i_reg_file (
		.clk      (clk),
		.rst_n    (rst_n),
		.rd_sel1  (rs),
		.rd_sel2  (rt),
		.rd_data1 (rf_a),
		.rd_data2 (rf_b),
		.fwd      (fwd)
	);

	always_comb begin
		val_a = fwd_pick(rs, rf_a);
		val_b = fwd_pick(rt, rf_b);
	end

	always_comb begin
		alu_sel = wisc_pkg::SEL_ADD;
		use_imm = 1'b0;
		reg_write = 1'b0;
		store = 1'b0;
		dest = rd;
		is_branch = 1'b0;
		is_halt = 1'b0;
		illegal = 1'b0;
		case (opcode)
			wisc_pkg::OP_HALT: is_halt = 1'b1;
			wisc_pkg::OP_NOP: ;
			wisc_pkg::OP_ADDI: begin
				use_imm = 1'b1;
				reg_write = 1'b1;
				dest = rt;
			end
			wisc_pkg::OP_SUBI: begin
				alu_sel = wisc_pkg::SEL_SUBI;
				reg_write = 1'b1;
				dest = rt;
			end
			wisc_pkg::OP_LBI: begin
				alu_sel = wisc_pkg::SEL_IMM;
				reg_write = 1'b1;
				dest = rs;
			end
			// Address is rs + imm, data is rt
			wisc_pkg::OP_ST: begin
				use_imm = 1'b1;
				store = 1'b1;
			end
			wisc_pkg::OP_BEQZ, wisc_pkg::OP_BNEZ: is_branch = 1'b1;
			wisc_pkg::OP_ALU: begin
				reg_write = 1'b1;
				case (funct)
					wisc_pkg::FN_ADD: alu_sel = wisc_pkg::SEL_ADD;
					wisc_pkg::FN_SUB: alu_sel = wisc_pkg::SEL_SUB;
					wisc_pkg::FN_XOR: alu_sel = wisc_pkg::SEL_XOR;
					default: alu_sel = wisc_pkg::SEL_ANDN;
				endcase
			end
			default: illegal = 1'b1;
		endcase
	end

	// BEQZ taken on zero, BNEZ on nonzero
	assign redirect = is_branch && ((opcode == wisc_pkg::OP_BEQZ) == (val_a == '0));
	assign target = fd_pc2 + imm8_sx;
	assign freeze = is_halt || illegal || stop_q;
	assign err = err_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			stop_q <= 1'b0;
			err_q <= 1'b0;
			ex.valid <= 1'b0;
			ex.reg_write <= 1'b0;
			ex.store <= 1'b0;
			ex.halt <= 1'b0;
		end else begin
			stop_q <= freeze;
			err_q <= err_q || illegal;
			ex.valid <= !stop_q;
			ex.reg_write <= reg_write && !stop_q;
			ex.store <= store && !stop_q;
			// Illegal opcode retires like HALT
			ex.halt <= (is_halt || illegal) && !stop_q;
		end
	end

	always_ff @(posedge clk) begin
		ex.op_a <= val_a;
		ex.op_b <= val_b;
		ex.imm <= imm_val;
		ex.alu_sel <= alu_sel;
		ex.use_imm <= use_imm;
		ex.dest <= dest;
	end

endmodule

// File: design/execute_stage.sv
/*
 * Execute: ALU and result select, then the execute/memory register.
 * The memory side of that register drives the store port directly.
 */
module execute_stage (
	input  logic            clk,
	input  logic            rst_n,
	id_ex_if.dst            ex,
	fwd_if.ex_src           fwd,
	output logic            mem_halt,
	output logic            dmem_wr,
	output wisc_pkg::word_t dmem_addr,
	output wisc_pkg::word_t dmem_wdata
);

	wisc_pkg::word_t b_val;
	wisc_pkg::word_t result;
	wisc_pkg::word_t store_data_q;

	assign b_val = ex.use_imm ? ex.imm : ex.op_b;

	// SUB and SUBI subtract rs from the other operand
	always_comb begin
		case (ex.alu_sel)
			wisc_pkg::SEL_ADD:  result = ex.op_a + b_val;
			wisc_pkg::SEL_SUBI: result = ex.imm - ex.op_a;
			wisc_pkg::SEL_SUB:  result = ex.op_b - ex.op_a;
			wisc_pkg::SEL_XOR:  result = ex.op_a ^ ex.op_b;
			wisc_pkg::SEL_ANDN: result = ex.op_a & ~ex.op_b;
			wisc_pkg::SEL_IMM:  result = ex.imm;
			default:            result = ex.op_a + b_val;
		endcase
	end

	assign fwd.ex_we = ex.valid && ex.reg_write;
	assign fwd.ex_idx = ex.dest;
	assign fwd.ex_data = result;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			fwd.mem_we <= 1'b0;
			dmem_wr <= 1'b0;
			mem_halt <= 1'b0;
		end else begin
			fwd.mem_we <= ex.valid && ex.reg_write;
			dmem_wr <= ex.valid && ex.store;
			mem_halt <= ex.valid && ex.halt;
		end
	end

	always_ff @(posedge clk) begin
		fwd.mem_idx <= ex.dest;
		fwd.mem_data <= result;
		store_data_q <= ex.op_b;
	end

	assign dmem_addr = fwd.mem_data;
	assign dmem_wdata = store_data_q;

endmodule

// File: design/writeback_stage.sv
/*
 * Memory/writeback register feeding the register file write port.
 * Also holds the sticky halted flag, set as a halt enters writeback.
 */
module writeback_stage (
	input  logic  clk,
	input  logic  rst_n,
	input  logic  mem_halt,
	fwd_if.wb_src fwd,
	output logic  halted
);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			fwd.wb_we <= 1'b0;
			halted <= 1'b0;
		end else begin
			fwd.wb_we <= fwd.mem_we;
			halted <= halted || mem_halt;
		end
	end

	always_ff @(posedge clk) begin
		fwd.wb_idx <= fwd.mem_idx;
		fwd.wb_data <= fwd.mem_data;
	end

endmodule

// File: design/wisc_core.sv
/*
 * Five-stage 16-bit core with external instruction and data memory ports.
 * Instruction memory answers instr_addr in the same cycle.
 */
module wisc_core #(
	parameter wisc_pkg::word_t RESET_PC = '0
) (
	input  logic              clk,
	input  logic              rst_n,
	input  wisc_pkg::instr_t  instr,
	output wisc_pkg::word_t   instr_addr,
	output logic              dmem_wr,
	output wisc_pkg::word_t   dmem_addr,
	output wisc_pkg::word_t   dmem_wdata,
	output logic              halted,
	output logic              err
);

	wisc_pkg::instr_t fd_instr;
	wisc_pkg::word_t  fd_pc2;
	wisc_pkg::word_t  target;
	logic redirect;
	logic freeze;
	logic mem_halt;

	id_ex_if id_ex ();
	fwd_if   fwd ();

	fetch_stage #(.RESET_PC(RESET_PC)) i_fetch (
		.clk      (clk),
		.rst_n    (rst_n),
		.redirect (redirect),
		.target   (target),
		.freeze   (freeze),
		.instr    (instr),
		.pc       (instr_addr),
		.fd_instr (fd_instr),
		.fd_pc2   (fd_pc2)
	);

	decode_stage i_decode (
		.clk      (clk),
		.rst_n    (rst_n),
		.fd_instr (fd_instr),
		.fd_pc2   (fd_pc2),
		.fwd      (fwd.consumer),
		.ex       (id_ex.src),
		.redirect (redirect),
		.target   (target),
		.freeze   (freeze),
		.err      (err)
	);

	execute_stage i_execute (
		.clk        (clk),
		.rst_n      (rst_n),
		.ex         (id_ex.dst),
		.fwd        (fwd.ex_src),
		.mem_halt   (mem_halt),
		.dmem_wr    (dmem_wr),
		.dmem_addr  (dmem_addr),
		.dmem_wdata (dmem_wdata)
	);

	writeback_stage i_writeback (
		.clk      (clk),
		.rst_n    (rst_n),
		.mem_halt (mem_halt),
		.fwd      (fwd.wb_src),
		.halted   (halted)
	);

endmodule

// File: test/wisc_core_properties.sv
/*
 * Control assertions for the core, attached to every wisc_core by bind.
 * Covers the state right after reset and the frozen state after a halt.
 */
module wisc_core_properties #(
	parameter wisc_pkg::word_t RESET_PC = '0
) (
	input logic            clk,
	input logic            rst_n,
	input logic            dmem_wr,
	input logic            halted,
	input logic            err,
	input wisc_pkg::word_t instr_addr
);

	timeunit 1ns;
	timeprecision 100ps;

	// First cycle out of reset
	assert property (@(posedge clk) $rose(rst_n) |->
		!dmem_wr && !halted && !err && instr_addr == RESET_PC)
		else $error("core outputs not at reset values after reset release");

	assert property (@(posedge clk) disable iff (!rst_n) halted |=> halted)
		else $error("halted dropped before reset");

	assert property (@(posedge clk) disable iff (!rst_n) halted |-> !dmem_wr)
		else $error("store issued after halt");

	// Fetch stays frozen once halted
	assert property (@(posedge clk) disable iff (!rst_n) halted |=> $stable(instr_addr))
		else $error("instruction address moved after halt");

endmodule

bind wisc_core wisc_core_properties #(.RESET_PC(RESET_PC)) i_wisc_core_properties (
	.clk        (clk),
	.rst_n      (rst_n),
	.dmem_wr    (dmem_wr),
	.halted     (halted),
	.err        (err),
	.instr_addr (instr_addr)
);

// File: test/wisc_core_tb.sv
/*
 * Testbench for the five-stage core. Runs two programs with a reset between them.
 * An in-order ISA model builds the expected store sequence, and assertions
 * compare every store port write against it.
 */
module wisc_core_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam logic [15:0] RESET_PC = 16'h0000;
	localparam int PROG_CYCLES = 60;
	// Two programs, each well under PROG_CYCLES, plus reset and drain margin
	localparam int CYCLE_LIMIT = 5 * PROG_CYCLES;

	logic        clk = 1'b0;
	logic        rst_n;
	logic [15:0] instr;
	logic [15:0] instr_addr;
	logic        dmem_wr;
	logic [15:0] dmem_addr;
	logic [15:0] dmem_wdata;
	logic        halted;
	logic        err;

	logic [15:0] imem [64];
	int          load_idx;
	logic [15:0] exp_addr_q [$];
	logic [15:0] exp_data_q [$];
	logic        head_valid = 1'b0;
	logic [15:0] head_addr = '0;
	logic [15:0] head_data = '0;
	logic        exp_err;
	int          cycle_count = 0;

	always #4 clk = ~clk;

	// Instruction memory answers in the same cycle
	assign instr = imem[instr_addr[6:1]];

	wisc_core #(.RESET_PC(RESET_PC)) i_wisc_core (
		.clk        (clk),
		.rst_n      (rst_n),
		.instr      (instr),
		.instr_addr (instr_addr),
		.dmem_wr    (dmem_wr),
		.dmem_addr  (dmem_addr),
		.dmem_wdata (dmem_wdata),
		.halted     (halted),
		.err        (err)
	);

	task automatic stop_run();
		$display("Errors found");
		$fatal(1, "Stopping at the first failure");
	endtask

	task automatic flag_problem(input string msg);
		$display("%s", msg);
		stop_run();
	endtask

	task automatic show_mismatch(input string msg);
		$display("mismatch at %0t: %s", $time, msg);
		stop_run();
	endtask

	function automatic logic [15:0] enc_imm5(input logic [4:0] op, input int rs, input int rt,
		input logic [4:0] imm);
		return {op, 3'(rs), 3'(rt), imm};
	endfunction

	function automatic logic [15:0] enc_imm8(input logic [4:0] op, input int rs,
		input logic [7:0] imm);
		return {op, 3'(rs), imm};
	endfunction

	function automatic logic [15:0] enc_alu(input int rs, input int rt, input int rd,
		input logic [1:0] fn);
		return {wisc_pkg::OP_ALU, 3'(rs), 3'(rt), 3'(rd), fn};
	endfunction

	task automatic put(input logic [15:0] w);
		imem[load_idx] = w;
		load_idx++;
	endtask

	// Unused words are NOPs tagged with their own index
	task automatic clear_imem();
		for (int i = 0; i < 64; i++)
			imem[i] = {wisc_pkg::OP_NOP, 11'(i)};
		load_idx = 0;
	endtask

	// In-order walk of the program image by the ISA rules
	task automatic build_expected();
		logic [15:0] regs [8];
		logic [15:0] pc, nxt, w, sx5, sx8, a, b;
		logic [2:0]  rs, rt, rd;
		int          steps;
		bit          done;
		for (int i = 0; i < 8; i++)
			regs[i] = '0;
		exp_addr_q.delete();
		exp_data_q.delete();
		exp_err = 1'b0;
		pc = RESET_PC;
		steps = 0;
		done = 0;
		while (!done && steps < 100) begin
			w = imem[pc[6:1]];
			rs = w[10:8];
			rt = w[7:5];
			rd = w[4:2];
			sx5 = {{11{w[4]}}, w[4:0]};
			sx8 = {{8{w[7]}}, w[7:0]};
			a = regs[rs];
			b = regs[rt];
			nxt = pc + 16'd2;
			case (w[15:11])
				wisc_pkg::OP_HALT: done = 1;
				wisc_pkg::OP_NOP: ;
				wisc_pkg::OP_ADDI: regs[rt] = a + sx5;
				wisc_pkg::OP_SUBI: regs[rt] = sx5 - a;
				wisc_pkg::OP_LBI: regs[rs] = sx8;
				wisc_pkg::OP_ST: begin
					exp_addr_q.push_back(a + sx5);
					exp_data_q.push_back(b);
				end
				wisc_pkg::OP_BEQZ: if (a == 0) nxt = pc + 16'd2 + sx8;
				wisc_pkg::OP_BNEZ: if (a != 0) nxt = pc + 16'd2 + sx8;
				wisc_pkg::OP_ALU: begin
					case (w[1:0])
						wisc_pkg::FN_ADD: regs[rd] = a + b;
						wisc_pkg::FN_SUB: regs[rd] = b - a;
						wisc_pkg::FN_XOR: regs[rd] = a ^ b;
						default: regs[rd] = a & ~b;
					endcase
				end
				default: begin
					exp_err = 1'b1;
					done = 1;
				end
			endcase
			pc = nxt;
			steps++;
		end
	endtask

	// Dependent ALU chains, branches, then HALT with a store behind it
	task automatic load_alu_branch_program();
		clear_imem();
		put(enc_imm8(wisc_pkg::OP_LBI, 1, 8'($urandom)));
		put(enc_imm8(wisc_pkg::OP_LBI, 2, 8'($urandom)));
		put(enc_alu(1, 2, 3, wisc_pkg::FN_ADD));
		put(enc_alu(3, 2, 4, wisc_pkg::FN_SUB));
		put(enc_alu(1, 3, 5, wisc_pkg::FN_XOR));
		put(enc_imm5(wisc_pkg::OP_ST, 5, 4, 5'd3));
		put(enc_alu(3, 4, 6, wisc_pkg::FN_ANDN));
		put(enc_imm5(wisc_pkg::OP_ADDI, 6, 7, 5'h1e));
		put(enc_imm5(wisc_pkg::OP_SUBI, 7, 1, 5'd7));
		put(enc_imm5(wisc_pkg::OP_ST, 6, 1, 5'd0));
		put(enc_imm5(wisc_pkg::OP_ST, 0, 7, 5'd1));
		put(enc_imm8(wisc_pkg::OP_LBI, 2, 8'd0));
		put(enc_imm8(wisc_pkg::OP_BEQZ, 2, 8'd2));
		put(enc_imm5(wisc_pkg::OP_ST, 0, 3, 5'd5));
		put(enc_imm5(wisc_pkg::OP_ST, 0, 1, 5'd6));
		put(enc_imm8(wisc_pkg::OP_BNEZ, 2, 8'd2));
		put(enc_imm5(wisc_pkg::OP_ST, 0, 4, 5'd7));
		put(enc_imm5(wisc_pkg::OP_ADDI, 0, 5, 5'd1));
		put(enc_imm8(wisc_pkg::OP_BNEZ, 5, 8'd2));
		put(enc_imm5(wisc_pkg::OP_ST, 0, 5, 5'd8));
		put(enc_imm8(wisc_pkg::OP_BEQZ, 5, 8'd2));
		put(enc_imm5(wisc_pkg::OP_ST, 5, 6, 5'd9));
		put({wisc_pkg::OP_HALT, 11'b0});
		put(enc_imm5(wisc_pkg::OP_ST, 0, 2, 5'd10));
	endtask

	task automatic load_illegal_program();
		clear_imem();
		put(enc_imm8(wisc_pkg::OP_LBI, 3, 8'($urandom)));
		put(enc_imm8(wisc_pkg::OP_LBI, 4, 8'($urandom)));
		put(enc_alu(3, 4, 5, wisc_pkg::FN_XOR));
		put(enc_imm5(wisc_pkg::OP_ST, 3, 5, 5'd2));
		put(enc_imm5(wisc_pkg::OP_ST, 4, 5, 5'h1f));
		// Opcode 11111 is not in the instruction set
		put({5'b11111, 11'b0});
		put(enc_imm5(wisc_pkg::OP_ST, 0, 3, 5'd4));
		put({wisc_pkg::OP_HALT, 11'b0});
	endtask

	task automatic run_program();
		logic [15:0] frozen_pc;
		@(posedge clk);
		rst_n <= 1'b0;
		build_expected();
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		assert (instr_addr == RESET_PC && !dmem_wr && !halted && !err)
			else show_mismatch("outputs differ from reset values after reset release");
		while (!halted)
			@(negedge clk);
		frozen_pc = instr_addr;
		// Pipeline is empty once halted, so a short wait shows any late store
		repeat (8) @(negedge clk);
		assert (exp_addr_q.size() == 0)
			else flag_problem("Expected stores did not appear before the halt");
		assert (halted && err == exp_err && instr_addr == frozen_pc)
			else show_mismatch($sformatf("halted %b err %b pc %h, expected 1 %b %h",
				halted, err, instr_addr, exp_err, frozen_pc));
	endtask

	// Expected head advances past each store seen on the port
	always @(posedge clk) begin
		if (rst_n && dmem_wr && exp_addr_q.size() > 0) begin
			void'(exp_addr_q.pop_front());
			void'(exp_data_q.pop_front());
		end
		head_valid <= exp_addr_q.size() > 0;
		head_addr <= (exp_addr_q.size() > 0) ? exp_addr_q[0] : '0;
		head_data <= (exp_data_q.size() > 0) ? exp_data_q[0] : '0;
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT)
			flag_problem("Run did not finish within the cycle limit");
	end

	assert property (@(posedge clk) disable iff (!rst_n) dmem_wr |-> head_valid)
		else flag_problem("A store appeared that the program should not produce");

	assert property (@(posedge clk) disable iff (!rst_n)
		dmem_wr && head_valid |-> dmem_addr == head_addr && dmem_wdata == head_data)
		else show_mismatch($sformatf("store addr %h data %h, expected addr %h data %h",
			$sampled(dmem_addr), $sampled(dmem_wdata), $sampled(head_addr),
			$sampled(head_data)));

	// Illegal opcode retires like HALT two stages later
	assert property (@(posedge clk) disable iff (!rst_n) $rose(err) |-> ##2 $rose(halted))
		else flag_problem("halted did not follow err by two cycles");

	initial begin
		rst_n = 1'b0;
		void'($urandom(32'h10c1d69e));
		load_alu_branch_program();
		run_program();
		load_illegal_program();
		run_program();
		if (exp_addr_q.size() == 0) begin
			$display("No errors");
			$finish;
		end else begin
			flag_problem("Expected store sequence not empty at the end of the run");
		end
	end

endmodule

// File: src.f
design/wisc_pkg.sv
design/id_ex_if.sv
design/fwd_if.sv
design/fetch_stage.sv
design/reg_file.sv
design/decode_stage.sv
design/execute_stage.sv
design/writeback_stage.sv
design/wisc_core.sv
test/wisc_core_properties.sv
test/wisc_core_tb.sv
